// ==== fetch_consts.svh ====
// Fetch constants shared by RTL and testbench; the NOP encoding is the OR32 l.nop word
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

////////////////////////////////
// Instruction word
////////////////////////////////

// Data path width in bits
`define FETCH_DW 32

// Inserted on flush, kill, fault and empty cycles
`define FETCH_NOP 32'h1541_0000

////////////////////////////////
// Address map
////////////////////////////////

// First fetch address after reset
`define FETCH_RESET_PC 32'h0000_0100

// Everything at or above this is not executable
`define FETCH_EXEC_LIMIT 32'h0000_1000

`endif

// ==== wb_pkg.sv ====
// Wishbone classic types for a 32-bit address bus; data width comes from FETCH_DW
`include "fetch_consts.svh"

package wb_pkg;

	// Byte address, always word aligned on this bus
	typedef logic [31:0] wb_adr_t;

	// Read data word
	typedef logic [`FETCH_DW-1:0] wb_dat_t;

	// One select bit per byte lane
	typedef logic [`FETCH_DW/8-1:0] wb_sel_t;

endpackage

// ==== fetch_pkg.sv ====
// Fetch response types; compile after wb_pkg since the struct reuses its data and address types
package fetch_pkg;

	////////////////////////////////
	// Response origin
	////////////////////////////////

	// Good word, bus error, or refused by the window check
	typedef enum logic [1:0] {
		tag_ok      = 2'd0,
		tag_bus_err = 2'd1,
		tag_prot    = 2'd2
	} fetch_tag_e;

	////////////////////////////////
	// Saved response
	////////////////////////////////

	// 66 bits in all
	typedef struct packed {
		wb_pkg::wb_dat_t insn;
		wb_pkg::wb_adr_t adr;
		fetch_tag_e      tag;
	} fetch_rsp_t;

endpackage

// ==== fetch_rsp_if.sv ====
// One fetch response from bus master to IF stage; no back-pressure, the stage must take or save it
`timescale 1ns/10ps

interface fetch_rsp_if;
	import wb_pkg::*;
	import fetch_pkg::*;

	// One-cycle valid pulse
	logic       rsp_ack;
	// Payload from the master
	wb_dat_t    rsp_dat;
	wb_adr_t    rsp_adr;
	fetch_tag_e rsp_tag;
	// Stage holds a saved response, master stays idle
	logic       hold;

	// Payload packed for the save register
	fetch_rsp_t rsp_word;

	assign rsp_word = '{insn: rsp_dat, adr: rsp_adr, tag: rsp_tag};

	modport master (
		output rsp_ack,
		output rsp_dat,
		output rsp_adr,
		output rsp_tag,
		input  hold
	);

	modport stage (
		input  rsp_ack,
		input  rsp_word,
		output hold
	);

endinterface

// ==== pc_gen.sv ====
// Fetch PC register; flush wins over advance and the redirect target is forced word aligned
`timescale 1ns/10ps
`include "fetch_consts.svh"

module pc_gen (
	input  logic            clk,
	input  logic            arst_n_i,
	// One pulse per delivered response
	input  logic            advance_i,
	// Redirect request and target
	input  logic            flush_i,
	input  wb_pkg::wb_adr_t flush_pc_i,
	// Current fetch address
	output wb_pkg::wb_adr_t pc_o
);
	import wb_pkg::*;

	wb_adr_t pc_q;
	wb_adr_t pc_next;
	wb_adr_t flush_pc_aligned;

	// Low two bits dropped, fetch is word granular
	assign flush_pc_aligned = {flush_pc_i[31:2], 2'b00};

	////////////////////////////////
	// Next PC
	////////////////////////////////

	always_comb begin
		pc_next = pc_q;
		if (flush_i) begin
			// Redirect
			pc_next = flush_pc_aligned;
		end else if (advance_i) begin
			// Sequential step, one word
			pc_next = pc_q + 32'd4;
		end
	end

	////////////////////////////////
	// PC register
	////////////////////////////////

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pc_q <= `FETCH_RESET_PC;
		end else begin
			pc_q <= pc_next;
		end
	end

	assign pc_o = pc_q;

endmodule

// ==== wb_fetch_master.sv ====
// Wishbone classic read master, one transfer in flight; no retry, err_i only tags the response
`timescale 1ns/10ps
`include "fetch_consts.svh"

module wb_fetch_master (
	input  logic            clk,
	input  logic            arst_n_i,
	input  wb_pkg::wb_adr_t pc_i,
	input  logic            flush_i,
	fetch_rsp_if.master     rsp,
	// Wishbone classic master side
	output logic            wb_cyc_o,
	output logic            wb_stb_o,
	output logic            wb_we_o,
	output wb_pkg::wb_adr_t wb_adr_o,
	output wb_pkg::wb_sel_t wb_sel_o,
	input  wb_pkg::wb_dat_t wb_dat_i,
	input  logic            wb_ack_i,
	input  logic            wb_err_i
);
	import wb_pkg::*;
	import fetch_pkg::*;

	typedef enum logic {
		st_idle,
		st_bus
	} state_e;

	state_e     state_q;
	logic       discard_q;
	logic       ack_q;
	logic       in_window;
	logic       start_ok;
	logic       bus_done;
	wb_adr_t    adr_q;
	wb_dat_t    dat_q;
	wb_adr_t    rsp_adr_q;
	fetch_tag_e tag_q;

	// Executable window check
	assign in_window = pc_i < `FETCH_EXEC_LIMIT;

	// Idle, no response pending pc advance, nothing saved, no redirect
	assign start_ok = (state_q == st_idle) && !ack_q && !rsp.hold && !flush_i;
	assign bus_done = (state_q == st_bus) && (wb_ack_i || wb_err_i);

	////////////////////////////////
	// Bus FSM
	////////////////////////////////

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q   <= st_idle;
			discard_q <= 1'b0;
			ack_q     <= 1'b0;
		end else begin
			ack_q <= 1'b0;
			case (state_q)
				st_idle: begin
					if (start_ok) begin
						if (in_window) begin
							state_q   <= st_bus;
							discard_q <= 1'b0;
						end else begin
							// Fault response, bus untouched
							ack_q <= 1'b1;
						end
					end
				end
				st_bus: begin
					// Redirect while waiting, drop the word when it comes
					if (flush_i) begin
						discard_q <= 1'b1;
					end
					if (wb_ack_i || wb_err_i) begin
						state_q <= st_idle;
						ack_q   <= !(discard_q || flush_i);
					end
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	////////////////////////////////
	// Address and response payload
	////////////////////////////////

	always_ff @(posedge clk) begin
		if (start_ok && in_window) begin
			adr_q <= {pc_i[31:2], 2'b00};
		end
		if (start_ok && !in_window) begin
			rsp_adr_q <= {pc_i[31:2], 2'b00};
			dat_q     <= `FETCH_NOP;
			tag_q     <= tag_prot;
		end else if (bus_done) begin
			rsp_adr_q <= adr_q;
			dat_q     <= wb_dat_i;
			tag_q     <= wb_err_i ? tag_bus_err : tag_ok;
		end
	end

	// Read only, full word
	assign wb_cyc_o = (state_q == st_bus);
	assign wb_stb_o = (state_q == st_bus);
	assign wb_we_o  = 1'b0;
	assign wb_sel_o = '1;
	assign wb_adr_o = adr_q;

	// Response side
	assign rsp.rsp_ack = ack_q;
	assign rsp.rsp_dat = dat_q;
	assign rsp.rsp_adr = rsp_adr_q;
	assign rsp.rsp_tag = tag_q;

endmodule

// ==== if_stage.sv ====
// IF stage with a one-entry save register; flush and kill blank the word, only kill masks faults
`timescale 1ns/10ps
`include "fetch_consts.svh"

module if_stage (
	input  logic            clk,
	input  logic            arst_n_i,
	fetch_rsp_if.stage      rsp,
	// Pipeline control
	input  logic            freeze_i,
	input  logic            flush_i,
	input  logic            kill_i,
	// To decode
	output wb_pkg::wb_dat_t insn_o,
	output wb_pkg::wb_adr_t pc_o,
	output logic            insn_valid_o,
	output logic            stall_o,
	// Exception flags
	output logic            exc_bus_err_o,
	output logic            exc_prot_o
);
	import wb_pkg::*;
	import fetch_pkg::*;

	fetch_rsp_t live;
	fetch_rsp_t save_q;
	logic       saved_q;
	logic       save_en;
	logic       avail;
	fetch_tag_e cur_tag;

	// Live response, faulted words replaced by NOP
	always_comb begin
		live = rsp.rsp_word;
		if (rsp.rsp_word.tag != tag_ok) begin
			live.insn = `FETCH_NOP;
		end
	end

	// Response lands while frozen and the slot is free
	assign save_en = rsp.rsp_ack && freeze_i && !flush_i && !saved_q;

	////////////////////////////////
	// Save register
	////////////////////////////////

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			saved_q <= 1'b0;
		end else if (flush_i) begin
			saved_q <= 1'b0;
		end else if (save_en) begin
			saved_q <= 1'b1;
		end else if (!freeze_i) begin
			// Presented this cycle
			saved_q <= 1'b0;
		end
	end

	// Payload, qualified by saved_q
	always_ff @(posedge clk) begin
		if (save_en) begin
			save_q <= live;
		end
	end

	// Master waits while the slot is full
	assign rsp.hold = saved_q;

	////////////////////////////////
	// Output select
	////////////////////////////////

	assign avail = saved_q || rsp.rsp_ack;

	always_comb begin
		if (kill_i || flush_i) begin
			insn_o = `FETCH_NOP;
		end else if (saved_q) begin
			insn_o = save_q.insn;
		end else if (rsp.rsp_ack) begin
			insn_o = live.insn;
		end else begin
			// Nothing fetched yet
			insn_o = `FETCH_NOP;
		end
	end

	assign pc_o = saved_q ? save_q.adr : live.adr;

	// Tag of whatever is on the outputs
	always_comb begin
		if (saved_q) begin
			cur_tag = save_q.tag;
		end else if (rsp.rsp_ack) begin
			cur_tag = live.tag;
		end else begin
			cur_tag = tag_ok;
		end
	end

	assign exc_bus_err_o = !kill_i && (cur_tag == tag_bus_err);
	assign exc_prot_o    = !kill_i && (cur_tag == tag_prot);

	assign insn_valid_o = avail && !freeze_i;
	assign stall_o      = !avail;

endmodule

// ==== fetch_top.sv ====
// Fetch front end top; plain Wishbone classic master ports, single outstanding read
`timescale 1ns/10ps

module fetch_top (
	input  logic            clk,
	input  logic            arst_n_i,
	// Pipeline control
	input  logic            freeze_i,
	input  logic            flush_i,
	input  wb_pkg::wb_adr_t flush_pc_i,
	input  logic            kill_i,
	// Wishbone classic master
	output logic            wb_cyc_o,
	output logic            wb_stb_o,
	output logic            wb_we_o,
	output wb_pkg::wb_adr_t wb_adr_o,
	output wb_pkg::wb_sel_t wb_sel_o,
	input  wb_pkg::wb_dat_t wb_dat_i,
	input  logic            wb_ack_i,
	input  logic            wb_err_i,
	// To decode
	output wb_pkg::wb_dat_t insn_o,
	output wb_pkg::wb_adr_t pc_o,
	output logic            insn_valid_o,
	output logic            stall_o,
	output logic            exc_bus_err_o,
	output logic            exc_prot_o
);
	import wb_pkg::*;

	// Current fetch address
	wb_adr_t fetch_pc;

	// Master to stage response channel
	fetch_rsp_if rsp_if ();

	// Every delivered response steps the PC
	pc_gen pc_gen_inst (
		.clk        (clk),
		.arst_n_i   (arst_n_i),
		.advance_i  (rsp_if.rsp_ack),
		.flush_i    (flush_i),
		.flush_pc_i (flush_pc_i),
		.pc_o       (fetch_pc)
	);

	wb_fetch_master wb_fetch_master_inst (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.pc_i     (fetch_pc),
		.flush_i  (flush_i),
		.rsp      (rsp_if.master),
		.wb_cyc_o (wb_cyc_o),
		.wb_stb_o (wb_stb_o),
		.wb_we_o  (wb_we_o),
		.wb_adr_o (wb_adr_o),
		.wb_sel_o (wb_sel_o),
		.wb_dat_i (wb_dat_i),
		.wb_ack_i (wb_ack_i),
		.wb_err_i (wb_err_i)
	);

	if_stage if_stage_inst (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.rsp           (rsp_if.stage),
		.freeze_i      (freeze_i),
		.flush_i       (flush_i),
		.kill_i        (kill_i),
		.insn_o        (insn_o),
		.pc_o          (pc_o),
		.insn_valid_o  (insn_valid_o),
		.stall_o       (stall_o),
		.exc_bus_err_o (exc_bus_err_o),
		.exc_prot_o    (exc_prot_o)
	);

endmodule

// ==== tb_wb_mem.sv ====
// Simulation-only Wishbone classic slave; registered ack, 0 to 3 wait states, one address answers err
`timescale 1ns/10ps
`include "fetch_consts.svh"

module tb_wb_mem #(
	parameter int          seed_init = 50,
	parameter logic [31:0] err_adr   = 32'h0000_0200
) (
	input  logic                 clk,
	input  logic                 arst_n_i,
	input  logic                 cyc_i,
	input  logic                 stb_i,
	input  logic [31:0]          adr_i,
	output logic [`FETCH_DW-1:0] dat_o,
	output logic                 ack_o,
	output logic                 err_o
);
	integer     seed = seed_init;
	// Wait states left before the next response
	logic [1:0] wait_cnt;

	always @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_o    <= 1'b0;
			err_o    <= 1'b0;
			dat_o    <= '0;
			wait_cnt <= 2'd0;
		end else begin
			// Response strobes last one cycle
			ack_o <= 1'b0;
			err_o <= 1'b0;
			if (cyc_i && stb_i && !ack_o && !err_o) begin
				if (wait_cnt != 2'd0) begin
					wait_cnt <= wait_cnt - 2'd1;
				end else begin
					// Contents rule, whole address folded in
					dat_o <= adr_i ^ 32'hA5A5_0000;
					if (adr_i == err_adr) begin
						err_o <= 1'b1;
					end else begin
						ack_o <= 1'b1;
					end
					// Latency of the next transfer
					wait_cnt <= 2'($random(seed));
				end
			end
		end
	end

endmodule

// ==== tb_fetch_top.sv ====
// Needs Verilator --timing --assert and fetch_consts.svh on the include path
`timescale 1ns/10ps
`include "fetch_consts.svh"

module tb_fetch_top;
	localparam int          tb_seed       = 50;
	localparam logic [31:0] err_adr       = 32'h0000_0200;
	localparam int          valid_timeout = 64;
	localparam int          bus_timeout   = 64;

	logic                 clk = 1'b0;
	logic                 arst_n_i;
	logic                 freeze_i = 1'b0;
	logic                 flush_i;
	logic [31:0]          flush_pc_i;
	logic                 kill_i;
	// Bus between DUT and memory model
	logic                 wb_cyc_o;
	logic                 wb_stb_o;
	logic                 wb_we_o;
	logic [31:0]          wb_adr_o;
	logic [3:0]           wb_sel_o;
	logic [`FETCH_DW-1:0] wb_dat_i;
	logic                 wb_ack_i;
	logic                 wb_err_i;
	// Decode side
	logic [`FETCH_DW-1:0] insn_o;
	logic [31:0]          pc_o;
	logic                 insn_valid_o;
	logic                 stall_o;
	logic                 exc_bus_err_o;
	logic                 exc_prot_o;

	integer      seed = tb_seed;
	logic        freeze_en = 1'b0;
	logic [2:0]  burst_left = 3'd0;
	// Address the next delivered instruction must carry
	logic [31:0] exp_pc;
	int          check_errors = 0;
	int          timeouts = 0;
	int          misses = 0;
	logic        bus_err_seen = 1'b0;
	logic        prot_seen = 1'b0;
	logic        replay_seen = 1'b0;

	always #5 clk = ~clk;

	fetch_top fetch_top_inst (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.freeze_i      (freeze_i),
		.flush_i       (flush_i),
		.flush_pc_i    (flush_pc_i),
		.kill_i        (kill_i),
		.wb_cyc_o      (wb_cyc_o),
		.wb_stb_o      (wb_stb_o),
		.wb_we_o       (wb_we_o),
		.wb_adr_o      (wb_adr_o),
		.wb_sel_o      (wb_sel_o),
		.wb_dat_i      (wb_dat_i),
		.wb_ack_i      (wb_ack_i),
		.wb_err_i      (wb_err_i),
		.insn_o        (insn_o),
		.pc_o          (pc_o),
		.insn_valid_o  (insn_valid_o),
		.stall_o       (stall_o),
		.exc_bus_err_o (exc_bus_err_o),
		.exc_prot_o    (exc_prot_o)
	);

	tb_wb_mem #(.seed_init(tb_seed), .err_adr(err_adr)) mem_inst (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.cyc_i    (wb_cyc_o),
		.stb_i    (wb_stb_o),
		.adr_i    (wb_adr_o),
		.dat_o    (wb_dat_i),
		.ack_o    (wb_ack_i),
		.err_o    (wb_err_i)
	);

	// Word expected on a delivered, unkilled instruction
	function automatic logic [31:0] expected_insn(input logic [31:0] adr);
		if (adr >= `FETCH_EXEC_LIMIT || adr == err_adr) begin
			return `FETCH_NOP;
		end
		return adr ^ 32'hA5A5_0000;
	endfunction

	//////////////////////////////
	// Reference PC and freeze bursts
	//////////////////////////////

	always @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			exp_pc <= `FETCH_RESET_PC;
		end else if (flush_i) begin
			exp_pc <= {flush_pc_i[31:2], 2'b00};
		end else if (insn_valid_o) begin
			exp_pc <= exp_pc + 32'd4;
		end
	end

	// Alternating runs of 1 to 8 cycles
	always @(posedge clk) begin
		if (!freeze_en) begin
			freeze_i   <= 1'b0;
			burst_left <= 3'd0;
		end else if (burst_left == 3'd0) begin
			freeze_i   <= ~freeze_i;
			burst_left <= 3'($random(seed));
		end else begin
			burst_left <= burst_left - 3'd1;
		end
	end

	// Which behaviors the stimulus actually reached
	always @(posedge clk) begin
		if (arst_n_i && insn_valid_o && !flush_i && exc_bus_err_o) begin
			bus_err_seen <= 1'b1;
		end
		if (arst_n_i && insn_valid_o && !flush_i && exc_prot_o) begin
			prot_seen <= 1'b1;
		end
		if (arst_n_i && freeze_i && !stall_o && !flush_i) begin
			replay_seen <= 1'b1;
		end
	end

	//////////////////////////////
	// Assertions
	//////////////////////////////

	pc_order: assert property (@(posedge clk) disable iff (!arst_n_i)
		(insn_valid_o && !flush_i) |-> (pc_o == exp_pc))
		else begin
			check_errors = check_errors + 1;
			$display("CHECK FAILED at %0t: pc_o got %h expected %h",
				$time, $sampled(pc_o), $sampled(exp_pc));
		end

	insn_word: assert property (@(posedge clk) disable iff (!arst_n_i)
		(insn_valid_o && !flush_i && !kill_i) |-> (insn_o == expected_insn(exp_pc)))
		else begin
			check_errors = check_errors + 1;
			$display("CHECK FAILED at %0t: insn_o got %h expected %h",
				$time, $sampled(insn_o), expected_insn($sampled(exp_pc)));
		end

	bus_err_flag: assert property (@(posedge clk) disable iff (!arst_n_i)
		(insn_valid_o && !flush_i) |-> (exc_bus_err_o == (!kill_i && exp_pc == err_adr)))
		else begin
			check_errors = check_errors + 1;
			$display("CHECK FAILED at %0t: exc_bus_err_o got %b expected %b", $time,
				$sampled(exc_bus_err_o),
				!$sampled(kill_i) && $sampled(exp_pc) == err_adr);
		end

	prot_flag: assert property (@(posedge clk) disable iff (!arst_n_i)
		(insn_valid_o && !flush_i) |->
		(exc_prot_o == (!kill_i && exp_pc >= `FETCH_EXEC_LIMIT)))
		else begin
			check_errors = check_errors + 1;
			$display("CHECK FAILED at %0t: exc_prot_o got %b expected %b", $time,
				$sampled(exc_prot_o),
				!$sampled(kill_i) && $sampled(exp_pc) >= `FETCH_EXEC_LIMIT);
		end

	// Killed slot carries a NOP and no flags
	kill_nop: assert property (@(posedge clk) disable iff (!arst_n_i)
		kill_i |-> (insn_o == `FETCH_NOP && !exc_bus_err_o && !exc_prot_o))
		else begin
			check_errors = check_errors + 1;
			$display("CHECK FAILED at %0t: insn_o/exc got %h/%b%b expected %h/00", $time,
				$sampled(insn_o), $sampled(exc_bus_err_o), $sampled(exc_prot_o),
				`FETCH_NOP);
		end

	exec_window: assert property (@(posedge clk) disable iff (!arst_n_i)
		wb_cyc_o |-> (wb_adr_o < `FETCH_EXEC_LIMIT))
		else begin
			check_errors = check_errors + 1;
			$display("CHECK FAILED at %0t: wb_adr_o got %h expected below %h",
				$time, $sampled(wb_adr_o), `FETCH_EXEC_LIMIT);
		end

	// Classic full-word read, strobe tracks cycle
	bus_read: assert property (@(posedge clk) disable iff (!arst_n_i)
		wb_stb_o == wb_cyc_o && (!wb_cyc_o || (!wb_we_o && wb_sel_o == 4'hF)))
		else begin
			check_errors = check_errors + 1;
			$display("CHECK FAILED at %0t: wb_stb_o/wb_we_o/wb_sel_o got %b/%b/%h %s %b/0/f",
				$time, $sampled(wb_stb_o), $sampled(wb_we_o), $sampled(wb_sel_o),
				"expected", $sampled(wb_cyc_o));
		end

	// Bus stays quiet while a response waits under freeze
	hold_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
		(freeze_i && !stall_o) |-> !wb_cyc_o)
		else begin
			check_errors = check_errors + 1;
			$display("CHECK FAILED at %0t: wb_cyc_o got %b expected 0",
				$time, $sampled(wb_cyc_o));
		end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	task automatic wait_valids(input int n);
		int got;
		int quiet;
		got = 0;
		quiet = 0;
		while (got < n && quiet < valid_timeout) begin
			@(posedge clk);
			if (insn_valid_o && !flush_i) begin
				got = got + 1;
				quiet = 0;
			end else begin
				quiet = quiet + 1;
			end
		end
		if (got < n) begin
			timeouts = timeouts + 1;
			$display("Timeout at %0t: only %0d of %0d instructions delivered", $time, got, n);
		end
	endtask

	// Redirect to target optionally while a bus read is still open
	task automatic flush_to(input logic [31:0] target, input logic in_flight);
		int n;
		n = 0;
		freeze_en <= 1'b0;
		do begin
			@(posedge clk);
			n = n + 1;
		end while (freeze_i && n < bus_timeout);
		if (freeze_i) begin
			timeouts = timeouts + 1;
			$display("Timeout at %0t: freeze did not drop before flush", $time);
		end
		n = 0;
		while (in_flight && !(wb_cyc_o && !wb_ack_i && !wb_err_i) && n < bus_timeout) begin
			@(posedge clk);
			n = n + 1;
		end
		if (n >= bus_timeout) begin
			timeouts = timeouts + 1;
			$display("Timeout at %0t: no bus cycle open before flush", $time);
		end
		flush_i    <= 1'b1;
		flush_pc_i <= target;
		@(posedge clk);
		flush_i   <= 1'b0;
		freeze_en <= 1'b1;
	endtask

	initial begin
		arst_n_i   <= 1'b0;
		flush_i    <= 1'b0;
		flush_pc_i <= '0;
		kill_i     <= 1'b0;
		repeat (10) @(posedge clk);
		arst_n_i  <= 1'b1;
		// Sequential stream past the error word at 0x200
		freeze_en <= 1'b1;
		wait_valids(80);
		flush_to(32'h0000_0400, 1'b1);
		wait_valids(12);
		// Into the non-executable region
		flush_to(`FETCH_EXEC_LIMIT, 1'b1);
		wait_valids(4);
		// Killed run across 0x200
		kill_i <= 1'b1;
		flush_to(32'h0000_01F0, 1'b0);
		wait_valids(8);
		kill_i <= 1'b0;
		wait_valids(6);
		if (!bus_err_seen) begin
			misses = misses + 1;
			$display("No bus error response was ever delivered");
		end
		if (!prot_seen) begin
			misses = misses + 1;
			$display("No protection fault was ever delivered");
		end
		if (!replay_seen) begin
			misses = misses + 1;
			$display("No response ever arrived under freeze");
		end
		$display("Errors: %0d failed checks, %0d timeouts, %0d behaviors not reached",
			check_errors, timeouts, misses);
		if (check_errors + timeouts + misses == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== fetch.f ====
+incdir+.
wb_pkg.sv
fetch_pkg.sv
fetch_rsp_if.sv
pc_gen.sv
wb_fetch_master.sv
if_stage.sv
fetch_top.sv
tb_wb_mem.sv
tb_fetch_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the fetch front end simulation with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fetch_top -f fetch.f -o tb_fetch_top

sim_out=$(./obj_dir/tb_fetch_top)
echo "$sim_out"

if grep -qx "ALL CHECKS PASSED" <<< "$sim_out"; then
	exit 0
else
	exit 1
fi
